// ==== source/fabric_pkg.sv ====
package fabric_pkg;

    // bus widths
    typedef logic [63:0] addr_t;        // byte address
    typedef logic [63:0] dword_t;       // bus data
    typedef logic [31:0] word_t;        // one ram word
    typedef logic [9:0]  word_index_t;  // ram word index
    typedef logic [3:0]  irq_t;         // interrupt vector

    // load/store type: bit 2 unsigned, bits 1:0 size
    typedef logic [2:0]  access_t;

    localparam logic [1:0] size_byte   = 2'd0;
    localparam logic [1:0] size_half   = 2'd1;
    localparam logic [1:0] size_word   = 2'd2;
    localparam logic [1:0] size_double = 2'd3;
    localparam int         unsigned_bit = 2;    // lbu lhu lwu

    // address map
    localparam addr_t ram_base  = 64'h0000_0000_0000_1000;
    localparam int    ram_words = 1024;         // 4 KiB
    localparam addr_t ram_bytes = addr_t'(ram_words * 4);
    localparam addr_t key_addr  = 64'h0000_0000_0000_2000;
    localparam addr_t uart_addr = 64'h0000_0000_0000_2008;

    localparam irq_t key_irq_vector = 4'd1;

    typedef enum logic [1:0] {
        region_ram,
        region_key,
        region_uart,
        region_none    // unmapped, reads give zero
    } region_t;

    // ram port beats, ld/sd use both
    typedef enum logic [1:0] {
        beat_idle,
        beat_low,
        beat_high
    } beat_state_t;

endpackage

// ==== source/bus_request_decoder.sv ====
`timescale 1ns/1ns

module bus_request_decoder (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  fabric_pkg::addr_t    bus_address,
    input  fabric_pkg::dword_t   bus_write_data,
    input  logic                 bus_read_enable,
    input  logic                 bus_write_enable,
    input  fabric_pkg::access_t  bus_read_type,
    input  fabric_pkg::access_t  bus_write_type,
    input  logic                 cmp_done,
    output logic                 req_start,
    output logic                 req_read,
    output logic                 req_write,
    output fabric_pkg::region_t  req_region,
    output fabric_pkg::addr_t    req_addr,
    output fabric_pkg::access_t  req_type,
    output fabric_pkg::dword_t   req_data,
    output logic                 busy
);

    fabric_pkg::region_t dec_region;  // region of the incoming address
    logic                accept;      // new request taken this edge

    assign accept = !busy && (bus_read_enable || bus_write_enable);

    // address map decode
    always_comb begin
        if (bus_address >= fabric_pkg::ram_base &&
            bus_address <  fabric_pkg::ram_base + fabric_pkg::ram_bytes) begin
            dec_region = fabric_pkg::region_ram;
        end else if (bus_address == fabric_pkg::key_addr) begin
            dec_region = fabric_pkg::region_key;
        end else if (bus_address == fabric_pkg::uart_addr) begin
            dec_region = fabric_pkg::region_uart;
        end else begin
            dec_region = fabric_pkg::region_none;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy      <= 1'b0;
            req_start <= 1'b0;
            req_read  <= 1'b0;
            req_write <= 1'b0;
        end else begin
            req_start <= 1'b0;                  // one cycle only
            if (accept) begin
                busy      <= 1'b1;
                req_start <= 1'b1;
                req_read  <= bus_read_enable;   // read wins over write
                req_write <= !bus_read_enable;
            end else if (cmp_done) begin
                busy <= 1'b0;                   // back to idle
            end
        end
    end

    // request held stable until completion
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            req_region <= dec_region;
            req_addr   <= bus_address;
            req_type   <= bus_read_enable ? bus_read_type : bus_write_type;
            req_data   <= bus_write_data;
        end
    end

    // master waits for done before the next enable
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        busy |-> !(bus_read_enable || bus_write_enable));

endmodule

// ==== source/word_ram_port.sv ====
`timescale 1ns/1ns

module word_ram_port (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 req_start,
    input  logic                 req_read,
    input  logic                 req_write,
    input  fabric_pkg::region_t  req_region,
    input  fabric_pkg::addr_t    req_addr,
    input  fabric_pkg::access_t  req_type,
    input  fabric_pkg::dword_t   req_data,
    output logic                 ram_done,
    output fabric_pkg::dword_t   ram_rdata
);

    fabric_pkg::word_t         mem [fabric_pkg::ram_words];
    fabric_pkg::beat_state_t   state;
    fabric_pkg::beat_state_t   cur_beat;     // beat acted on this cycle
    fabric_pkg::addr_t         offset;       // byte offset into ram
    fabric_pkg::word_index_t   idx;
    fabric_pkg::word_index_t   idx_next;     // upper word of ld/sd
    logic [1:0]                size;
    logic                      is_unsigned;
    logic                      ram_sel;
    logic [4:0]                lane_shift;   // 8 * byte offset
    fabric_pkg::word_t         shifted;
    fabric_pkg::word_t         store_mask;
    fabric_pkg::word_t         store_bits;
    fabric_pkg::word_t         merged;
    fabric_pkg::dword_t        load_ext;

    assign offset      = req_addr - fabric_pkg::ram_base;
    assign idx         = offset[$bits(fabric_pkg::word_index_t)+1:2];
    assign idx_next    = idx + 1'b1;
    assign size        = req_type[1:0];
    assign is_unsigned = req_type[fabric_pkg::unsigned_bit];
    assign lane_shift  = {offset[1:0], 3'b000};
    assign ram_sel     = req_start && (req_region == fabric_pkg::region_ram)
                         && (req_read || req_write);

    // a starting ld/sd is already its low beat
    always_comb begin
        cur_beat = state;
        if (state == fabric_pkg::beat_idle && ram_sel && size == fabric_pkg::size_double) begin
            cur_beat = fabric_pkg::beat_low;
        end
    end

    // loads shift then extend
    assign shifted = mem[idx] >> lane_shift;
    always_comb begin
        case (size)
            fabric_pkg::size_byte:
                load_ext = is_unsigned ? {56'd0, shifted[7:0]}
                                       : {{56{shifted[7]}}, shifted[7:0]};
            fabric_pkg::size_half:
                load_ext = is_unsigned ? {48'd0, shifted[15:0]}
                                       : {{48{shifted[15]}}, shifted[15:0]};
            fabric_pkg::size_word:
                load_ext = is_unsigned ? {32'd0, shifted}
                                       : {{32{shifted[31]}}, shifted};
            default: load_ext = {32'd0, shifted};   // ld goes through beats
        endcase
    end

    // little-endian lane merge for stores
    always_comb begin
        case (size)
            fabric_pkg::size_byte: store_mask = 32'h0000_00ff << lane_shift;
            fabric_pkg::size_half: store_mask = 32'h0000_ffff << lane_shift;
            default:               store_mask = '1;
        endcase
    end
    assign store_bits = req_data[31:0] << lane_shift;
    assign merged     = (mem[idx] & ~store_mask) | (store_bits & store_mask);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= fabric_pkg::beat_idle;
            ram_done <= 1'b0;
        end else begin
            ram_done <= 1'b0;
            case (cur_beat)
                fabric_pkg::beat_low:  state <= fabric_pkg::beat_high;
                fabric_pkg::beat_high: begin
                    state    <= fabric_pkg::beat_idle;
                    ram_done <= 1'b1;                  // ld/sd finished
                end
                default: ram_done <= ram_sel;          // single beat access
            endcase
        end
    end

    // memory and read data
    always_ff @(posedge CLOCK_50) begin
        case (cur_beat)
            fabric_pkg::beat_low: begin
                if (req_write) mem[idx] <= req_data[31:0];
                else           ram_rdata[31:0] <= mem[idx];
            end
            fabric_pkg::beat_high: begin
                if (req_write) mem[idx_next] <= req_data[63:32];
                else           ram_rdata[63:32] <= mem[idx_next];
            end
            default: begin
                if (ram_sel && req_write)     mem[idx] <= merged;
                else if (ram_sel && req_read) ram_rdata <= load_ext;
            end
        endcase
    end

    // a request landing in the high beat would be lost
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        state == fabric_pkg::beat_high |-> !ram_sel);

    // halfwords stay inside one word
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ram_sel && size == fabric_pkg::size_half |-> !req_addr[0]);

endmodule

// ==== source/key_interrupt_unit.sv ====
`timescale 1ns/1ns

module key_interrupt_unit (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 key_valid,
    input  logic [7:0]           key_ascii,
    input  logic                 interrupt_ack,
    input  logic                 req_start,
    input  logic                 req_read,
    input  logic                 req_write,
    input  fabric_pkg::region_t  req_region,
    input  fabric_pkg::dword_t   req_data,
    output logic                 key_done,
    output fabric_pkg::dword_t   key_rdata,
    output fabric_pkg::irq_t     interrupt_vector,
    output logic                 uart_valid,
    output logic [7:0]           uart_data
);

    logic [7:0] key_code;   // last code seen
    logic       key_sel;
    logic       uart_sel;

    assign key_sel  = req_start && (req_region == fabric_pkg::region_key);
    assign uart_sel = req_start && (req_region == fabric_pkg::region_uart);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code         <= 8'd0;
            interrupt_vector <= '0;
            key_done         <= 1'b0;
            uart_valid       <= 1'b0;
        end else begin
            if (key_valid) key_code <= key_ascii;
            if (key_valid && key_ascii != 8'd0) interrupt_vector <= fabric_pkg::key_irq_vector;
            if (interrupt_vector != '0 && interrupt_ack) interrupt_vector <= '0;  // ack wins
            key_done   <= key_sel || uart_sel;      // both registers answer in one cycle
            uart_valid <= uart_sel && req_write;    // single pulse per write
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (key_sel || uart_sel) key_rdata <= (key_sel && req_read) ? {56'd0, key_code} : '0;
        if (uart_sel && req_write) uart_data <= req_data[7:0];  // low byte only
    end

endmodule

// ==== source/bus_response.sv ====
`timescale 1ns/1ns

module bus_response (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  logic                 req_start,
    input  logic                 req_read,
    input  fabric_pkg::region_t  req_region,
    input  logic                 ram_done,
    input  fabric_pkg::dword_t   ram_rdata,
    input  logic                 key_done,
    input  fabric_pkg::dword_t   key_rdata,
    output logic                 cmp_done,
    output fabric_pkg::dword_t   bus_read_data,
    output logic                 bus_read_done,
    output logic                 bus_write_done
);

    logic               none_done;   // unmapped completion
    fabric_pkg::dword_t cmp_rdata;

    assign cmp_done  = ram_done || key_done || none_done;
    assign cmp_rdata = ram_done ? ram_rdata : (key_done ? key_rdata : '0);  // unmapped reads 0

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            none_done      <= 1'b0;
            bus_read_done  <= 1'b1;   // idle after reset
            bus_write_done <= 1'b1;
        end else begin
            none_done <= req_start && (req_region == fabric_pkg::region_none);
            if (req_start) begin
                if (req_read) bus_read_done <= 1'b0;
                else          bus_write_done <= 1'b0;
            end else if (cmp_done) begin
                bus_read_done  <= 1'b1;
                bus_write_done <= 1'b1;
            end
        end
    end

    // data held until the next read completes
    always_ff @(posedge CLOCK_50) begin
        if (cmp_done && !bus_read_done) bus_read_data <= cmp_rdata;
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) bus_read_done || bus_write_done);

endmodule

// ==== source/bus_fabric_top.sv ====
`timescale 1ns/1ns

module bus_fabric_top (
    input  logic                 CLOCK_50,
    input  logic                 KEY0,
    input  fabric_pkg::addr_t    bus_address,
    input  fabric_pkg::dword_t   bus_write_data,
    input  logic                 bus_read_enable,
    input  logic                 bus_write_enable,
    input  fabric_pkg::access_t  bus_read_type,
    input  fabric_pkg::access_t  bus_write_type,
    input  logic                 key_valid,
    input  logic [7:0]           key_ascii,
    input  logic                 interrupt_ack,
    output fabric_pkg::dword_t   bus_read_data,
    output logic                 bus_read_done,
    output logic                 bus_write_done,
    output fabric_pkg::irq_t     interrupt_vector,
    output logic                 uart_valid,
    output logic [7:0]           uart_data
);

    // request side
    logic                req_start;
    logic                req_read;
    logic                req_write;
    fabric_pkg::region_t req_region;
    fabric_pkg::addr_t   req_addr;
    fabric_pkg::access_t req_type;
    fabric_pkg::dword_t  req_data;
    // completions
    logic                cmp_done;
    logic                ram_done;
    fabric_pkg::dword_t  ram_rdata;
    logic                key_done;
    fabric_pkg::dword_t  key_rdata;

    bus_request_decoder i_bus_request_decoder (
        .CLOCK_50, .KEY0, .bus_address, .bus_write_data, .bus_read_enable,
        .bus_write_enable, .bus_read_type, .bus_write_type, .cmp_done,
        .req_start, .req_read, .req_write, .req_region, .req_addr, .req_type,
        .req_data, .busy ()
    );

    word_ram_port i_word_ram_port (
        .CLOCK_50, .KEY0, .req_start, .req_read, .req_write, .req_region,
        .req_addr, .req_type, .req_data, .ram_done, .ram_rdata
    );

    key_interrupt_unit i_key_interrupt_unit (
        .CLOCK_50, .KEY0, .key_valid, .key_ascii, .interrupt_ack, .req_start,
        .req_read, .req_write, .req_region, .req_data, .key_done, .key_rdata,
        .interrupt_vector, .uart_valid, .uart_data
    );

    bus_response i_bus_response (
        .CLOCK_50, .KEY0, .req_start, .req_read, .req_region, .ram_done,
        .ram_rdata, .key_done, .key_rdata, .cmp_done, .bus_read_data,
        .bus_read_done, .bus_write_done
    );

endmodule

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;    // compares done
int error_count = 0;    // wrong values plus protocol trouble

// 64-bit bus data
task automatic check_dword(input string name, input fabric_pkg::dword_t expected,
                           input fabric_pkg::dword_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s expected %h got %h",
                 $time, name, expected, actual);
    end
endtask

// interrupt vector
task automatic check_irq(input string name, input fabric_pkg::irq_t expected,
                         input fabric_pkg::irq_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s expected %h got %h",
                 $time, name, expected, actual);
    end
endtask

task automatic check_byte(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED at %0t ns: %s expected %h got %h",
                 $time, name, expected, actual);
    end
endtask

`endif

// ==== verification/tb_bus_fabric.sv ====
`timescale 1ns/1ns

module tb_bus_fabric;

    localparam int reset_cycles = 8;
    localparam int done_bound   = 8;    // cycles a done flag may take
    localparam int drive_delay  = 2;    // ns after the rising edge

    logic                CLOCK_50;
    logic                KEY0;
    fabric_pkg::addr_t   bus_address;
    fabric_pkg::dword_t  bus_write_data;
    logic                bus_read_enable;
    logic                bus_write_enable;
    fabric_pkg::access_t bus_read_type;
    fabric_pkg::access_t bus_write_type;
    logic                key_valid;
    logic [7:0]          key_ascii;
    logic                interrupt_ack;
    fabric_pkg::dword_t  bus_read_data;
    logic                bus_read_done;
    logic                bus_write_done;
    fabric_pkg::irq_t    interrupt_vector;
    logic                uart_valid;
    logic [7:0]          uart_data;

    // one entry per stimulus line
    logic [7:0]          op_q[$];
    fabric_pkg::addr_t   addr_q[$];
    fabric_pkg::access_t type_q[$];
    fabric_pkg::dword_t  data_q[$];
    fabric_pkg::dword_t  exp_q[$];

    int                  seed = 32'h2fd6_816a;
    int                  cycle_count = 0;
    int                  cycle_limit = 0;   // armed once stimulus is loaded
    int                  uart_pulses = 0;
    logic [7:0]          uart_seen;         // byte of the last console pulse

    `include "tb_checks.svh"

    bus_fabric_top i_bus_fabric_top (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;    // 10 ns period
    end

    // run limit
    always @(posedge CLOCK_50) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // counts console cycles on the falling edge
    always @(negedge CLOCK_50) begin
        if (KEY0 && uart_valid) begin
            uart_pulses++;
            uart_seen = uart_data;
        end
    end

    task automatic next_cycle();
        @(posedge CLOCK_50);
        #drive_delay;
    endtask

    // done must drop and then come back high
    task automatic wait_done(input logic is_read, output logic ok);
        logic seen_low;
        logic flag;
        int   cycles;
        seen_low = 1'b0;
        ok       = 1'b0;
        for (cycles = 0; cycles < done_bound && !ok; cycles++) begin
            flag = is_read ? bus_read_done : bus_write_done;
            if (!flag) seen_low = 1'b1;
            else if (seen_low) ok = 1'b1;
            if (!ok) next_cycle();
        end
        if (!ok) begin
            error_count++;
            $display("error at %0t ns: %s done did not return within %0d cycles",
                     $time, is_read ? "read" : "write", done_bound);
        end
    endtask

    task automatic run_access(input logic is_read, input fabric_pkg::addr_t addr,
                              input fabric_pkg::access_t typ, input fabric_pkg::dword_t data,
                              input fabric_pkg::dword_t expected);
        logic ok;
        int   pulses_before;
        pulses_before  = uart_pulses;
        bus_address    = addr;
        bus_write_data = data;
        if (is_read) begin
            bus_read_type   = typ;
            bus_read_enable = 1'b1;
        end else begin
            bus_write_type   = typ;
            bus_write_enable = 1'b1;
        end
        next_cycle();
        bus_read_enable  = 1'b0;            // single-cycle enable
        bus_write_enable = 1'b0;
        wait_done(is_read, ok);
        if (ok && is_read) check_dword("bus_read_data", expected, bus_read_data);
        if (ok && !is_read && addr == fabric_pkg::uart_addr) begin
            next_cycle();                   // a stretched pulse gets counted too
            if (uart_pulses - pulses_before != 1) begin
                error_count++;
                $display("error at %0t ns: expected one uart_valid pulse but saw %0d",
                         $time, uart_pulses - pulses_before);
            end
            check_byte("uart_data", expected[7:0], uart_seen);
        end
    endtask

    task automatic key_event(input logic [7:0] ascii, input fabric_pkg::irq_t expected);
        key_valid = 1'b1;
        key_ascii = ascii;
        next_cycle();
        key_valid = 1'b0;
        check_irq("interrupt_vector", expected, interrupt_vector);
    endtask

    task automatic ack_interrupt(input fabric_pkg::irq_t expected);
        interrupt_ack = 1'b1;
        next_cycle();
        interrupt_ack = 1'b0;
        check_irq("interrupt_vector", expected, interrupt_vector);
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [63:0] addr;
        logic [63:0] typ;
        logic [63:0] data;
        logic [63:0] expected;
        fd = $fopen("verification/fabric_stimulus.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("error: cannot open verification/fabric_stimulus.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;    // blank or column notes
            n = $sscanf(line, "%c %h %h %h %h", op, addr, typ, data, expected);
            if (n != 5) begin
                error_count++;
                $display("error: stimulus line has %0d fields instead of 5", n);
                continue;
            end
            op_q.push_back(op);
            addr_q.push_back(addr);
            type_q.push_back(typ[2:0]);
            data_q.push_back(data);
            exp_q.push_back(expected);
        end
        $fclose(fd);
    endtask

    initial begin
        int    errors_before;
        int    gap;
        int    t;
        string verdict;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        bus_read_type    = '0;
        bus_write_type   = '0;
        key_valid        = 1'b0;
        key_ascii        = 8'd0;
        interrupt_ack    = 1'b0;
        load_stimulus();
        cycle_limit = op_q.size() * 12 + reset_cycles + 2;   // slack for release
        repeat (reset_cycles) @(posedge CLOCK_50);
        #drive_delay;
        KEY0 = 1'b1;
        next_cycle();
        for (t = 0; t < op_q.size(); t++) begin
            errors_before = error_count;
            gap = $unsigned($random(seed)) % 4;     // idle 0..3 cycles
            repeat (gap) next_cycle();
            case (op_q[t])
                "W", "R": run_access(op_q[t] == "R", addr_q[t], type_q[t], data_q[t], exp_q[t]);
                "K":      key_event(data_q[t][7:0], exp_q[t][3:0]);
                "A":      ack_interrupt(exp_q[t][3:0]);
                default: begin
                    error_count++;
                    $display("error: unknown op letter %c in test %0d", op_q[t], t);
                end
            endcase
            verdict = (error_count == errors_before) ? "ok" : "failed";
            $display("test %0d op %c addr %h: %s", t, op_q[t], addr_q[t], verdict);
            next_cycle();
        end
        $display("tests %0d  checks %0d  errors %0d", op_q.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
source/fabric_pkg.sv
source/bus_request_decoder.sv
source/word_ram_port.sv
source/key_interrupt_unit.sv
source/bus_response.sv
source/bus_fabric_top.sv
verification/tb_bus_fabric.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bus fabric testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_bus_fabric -f compile.f \
    && ./obj_dir/Vtb_bus_fabric | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

// ==== verification/fabric_stimulus.txt ====
# columns op address type data expected with all but op in hex
# op W write R read K key event A interrupt ack and type bit 2 means unsigned
W 1000 2 0000000089ABCDEF 0
R 1000 2 0 FFFFFFFF89ABCDEF
R 1000 6 0 0000000089ABCDEF
W 1002 0 80 0
R 1000 2 0 FFFFFFFF8980CDEF
R 1002 0 0 FFFFFFFFFFFFFF80
R 1002 4 0 80
W 1002 1 1234 0
R 1002 5 0 1234
R 1000 0 0 FFFFFFFFFFFFFFEF
W 1010 3 DEADBEEF0BADF00D 0
R 1010 3 0 DEADBEEF0BADF00D
R 1014 2 0 FFFFFFFFDEADBEEF
R 1014 6 0 00000000DEADBEEF
K 0 0 00 0
K 0 0 41 1
R 2000 2 0 41
A 0 0 0 0
W 2008 2 12A5 A5
R 3000 2 0 0
